//--- rtl/bus_pkg.sv
package bus_pkg;

  // one master request, held steady while waitrequest is high
  typedef struct packed {
    logic [31:0] address;    // byte address
    logic        read;       // read level
    logic        write;      // write level
    logic [31:0] writedata;
    logic [3:0]  byteenable; // one bit per byte lane
  } bus_req_t;

  // targets reachable through the fabric
  typedef enum logic [2:0] {
    REGION_NONE,  // unmapped, reads as zero
    REGION_SRAM,
    REGION_VIDEO,
    REGION_CACHE,
    REGION_KEYB
  } region_e;

  // compared against address[31:16]
  localparam logic [15:0] SRAM_TAG  = 16'h0200; // 64k window, 2k used
  localparam logic [15:0] VIDEO_TAG = 16'h0204;
  localparam logic [15:0] CACHE_TAG = 16'h0205;
  localparam logic [15:0] KEYB_TAG  = 16'h0206;

  // main sram geometry
  localparam int unsigned SRAM_WORDS = 512;
  localparam int unsigned SRAM_AW    = 9;   // word index is address[10:2]

  // register offset within a region, address[15:2]
  localparam int unsigned WORD_OFS_W = 14;

endpackage

//--- rtl/periph_pkg.sv
package periph_pkg;

  typedef struct packed {
    logic        flush; // level, held until rewritten
    logic [14:0] page;
  } flush_ctl_t;

  typedef struct packed {
    logic [1:0]  mode;
    logic [15:0] line_base; // first line of the frame buffer
    logic        block;     // blank the display
  } vga_ctl_t;

  // cache view of a write word
  typedef struct packed {
    logic        flush;  // bit 31
    logic [15:0] rsvd;
    logic [14:0] page;   // bits 14..0
  } cache_wdata_t;

  // video view, low half carries the field picked by the offset
  typedef struct packed {
    logic [15:0] rsvd;
    logic [15:0] field; // mode [1:0], line base [15:0], block [0]
  } video_wdata_t;

  typedef union packed {
    cache_wdata_t cache;
    video_wdata_t video;
  } ctrl_wdata_u;

  typedef struct packed {
    logic       valid; // set on the last edge, cleared by a bus read
    logic [9:0] bits;  // start, d0..d7, parity
  } key_frame_t;

  localparam logic [15:0] KEY_IDLE_TIMEOUT = 16'hFFFF;
  localparam int unsigned KEY_FRAME_EDGES  = 11;
  localparam int unsigned KEY_BITPOS_W     = 4;

  localparam logic [1:0]  VGA_MODE_RESET   = 2'd3;

  // register offsets, in words
  localparam int unsigned CACHE_OFS_FLUSH = 0;
  localparam int unsigned VGA_OFS_MODE    = 0;
  localparam int unsigned VGA_OFS_LINE    = 1;
  localparam int unsigned VGA_OFS_BLOCK   = 2;

endpackage

//--- rtl/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder
  import bus_pkg::*;
(
  input  bus_req_t                bus_req,
  output region_e                 region,
  output logic [WORD_OFS_W-1:0]   word_ofs
);

  logic [15:0] addr_hi; // region tag half of the address

  assign addr_hi  = bus_req.address[31:16];
  assign word_ofs = bus_req.address[WORD_OFS_W+1:2]; // drop byte bits

  // the old sdram window and every gap fall through to none
  always_comb begin
    case (addr_hi)
      SRAM_TAG:  region = REGION_SRAM;
      VIDEO_TAG: region = REGION_VIDEO;
      CACHE_TAG: region = REGION_CACHE;
      KEYB_TAG:  region = REGION_KEYB;
      default:   region = REGION_NONE;
    endcase
  end

  // master must never issue both levels at once
  always_comb begin
    assert final (!(bus_req.read && bus_req.write))
      else $error("bus_decoder: read and write high together");
  end

endmodule

//--- rtl/main_sram.sv
`timescale 1ns/1ps

module main_sram
  import bus_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  input  bus_req_t    bus_req,
  input  region_e     region,
  output logic [31:0] rdata,
  output logic        wait_req
);

  logic [31:0]        mem [SRAM_WORDS]; // 2k bytes
  logic [SRAM_AW-1:0] word_idx;
  logic               sram_cs;
  logic               sram_rd;
  logic               sram_wr;
  logic               read_ack;         // set for the data cycle of a read

  assign sram_cs  = (region == REGION_SRAM);
  assign sram_rd  = sram_cs && bus_req.read;
  assign sram_wr  = sram_cs && bus_req.write;
  assign word_idx = bus_req.address[SRAM_AW+1:2]; // address[10:2]

  // first read cycle stalls, ack frees the second
  assign wait_req = sram_rd && !read_ack;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      read_ack <= 1'b0;
    end else if (sram_rd && !read_ack) begin
      read_ack <= 1'b1;              // data lands this edge
    end else if (!sram_rd && read_ack) begin
      read_ack <= 1'b0;              // read dropped, rearm
    end
  end

  // byte lanes written independently, read registered
  always_ff @(posedge clk) begin
    if (sram_wr) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (bus_req.byteenable[lane]) begin
          mem[word_idx][lane*8 +: 8] <= bus_req.writedata[lane*8 +: 8];
        end
      end
    end
    if (sram_rd) begin
      rdata <= mem[word_idx]; // valid in the ack cycle
    end
  end

  // one wait cycle per read, never two in a row
  a_single_wait: assert property (
    @(posedge clk) disable iff (!reset_n)
    wait_req |=> !wait_req
  ) else $error("main_sram: wait request held for a second cycle");

endmodule

//--- rtl/ctrl_regs.sv
`timescale 1ns/1ps

module ctrl_regs
  import bus_pkg::*, periph_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset_n,
  input  bus_req_t              bus_req,
  input  region_e               region,
  input  logic [WORD_OFS_W-1:0] word_ofs,
  output flush_ctl_t            cache_ctl,
  output vga_ctl_t              vga_ctl
);

  ctrl_wdata_u wd;        // same word, cache or video view
  logic        cache_wr;
  logic        video_wr;

  assign wd       = bus_req.writedata;
  assign cache_wr = bus_req.write && (region == REGION_CACHE);
  assign video_wr = bus_req.write && (region == REGION_VIDEO);

  // flush control, only offset 0 is backed
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      cache_ctl <= '0;
    end else if (cache_wr && word_ofs == WORD_OFS_W'(CACHE_OFS_FLUSH)) begin
      cache_ctl.flush <= wd.cache.flush; // bit 31
      cache_ctl.page  <= wd.cache.page;  // bits 14..0
    end
  end

  // video control, field picked by offset
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      vga_ctl.mode      <= VGA_MODE_RESET;
      vga_ctl.line_base <= '0;
      vga_ctl.block     <= 1'b0;
    end else if (video_wr) begin
      case (word_ofs)
        WORD_OFS_W'(VGA_OFS_MODE): begin
          vga_ctl.mode <= wd.video.field[1:0];
        end
        WORD_OFS_W'(VGA_OFS_LINE): begin
          vga_ctl.line_base <= wd.video.field;
        end
        WORD_OFS_W'(VGA_OFS_BLOCK): begin
          vga_ctl.block <= wd.video.field[0];
        end
        default: begin
          // unbacked offset, write dropped
        end
      endcase
    end
  end

endmodule

//--- rtl/ps2_key_rx.sv
`timescale 1ns/1ps

module ps2_key_rx
  import bus_pkg::*, periph_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic       key_clk,
  input  logic       key_data,
  input  bus_req_t   bus_req,
  input  region_e    region,
  output key_frame_t frame
);

  logic                    clk_meta;   // 2-ff sync on the ps2 clock
  logic                    clk_sync;
  logic                    clk_prev;   // for edge detect
  logic                    data_meta;  // data kept in step with clock
  logic                    data_sync;
  logic                    clk_fall;
  logic                    key_rd;
  logic [15:0]             idle_cnt;   // cycles since last edge
  logic [KEY_BITPOS_W-1:0] bit_pos;

  assign clk_fall = clk_prev && !clk_sync;
  assign key_rd   = (region == REGION_KEYB) && bus_req.read;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      clk_meta  <= 1'b1;             // ps2 lines idle high
      clk_sync  <= 1'b1;
      clk_prev  <= 1'b1;
      data_meta <= 1'b1;
      data_sync <= 1'b1;
    end else begin
      clk_meta  <= key_clk;
      clk_sync  <= clk_meta;
      clk_prev  <= clk_sync;
      data_meta <= key_data;
      data_sync <= data_meta;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      idle_cnt <= '0;
      bit_pos  <= '0;
      frame    <= '0;
    end else begin
      if (idle_cnt != KEY_IDLE_TIMEOUT) begin
        idle_cnt <= idle_cnt + 16'd1;  // saturates
      end
      if (key_rd) begin
        frame.valid <= 1'b0;           // read clears
      end
      if (clk_fall) begin
        idle_cnt <= '0;
        if (idle_cnt == KEY_IDLE_TIMEOUT) begin
          frame.bits[0] <= data_sync;  // long gap, restart at start bit
          bit_pos       <= KEY_BITPOS_W'(1);
        end else if (bit_pos == KEY_BITPOS_W'(KEY_FRAME_EDGES - 1)) begin
          bit_pos     <= '0;           // stop bit, not stored
          frame.valid <= 1'b1;         // beats a read on the same edge
        end else begin
          frame.bits[bit_pos] <= data_sync;
          bit_pos             <= bit_pos + KEY_BITPOS_W'(1);
        end
      end
    end
  end

  a_bitpos_range: assert property (
    @(posedge clk) disable iff (!reset_n)
    bit_pos < KEY_BITPOS_W'(KEY_FRAME_EDGES)
  ) else $error("ps2_key_rx: bit position past the frame");

endmodule

//--- rtl/read_return.sv
`timescale 1ns/1ps

module read_return
  import bus_pkg::*, periph_pkg::*;
(
  input  region_e     region,
  input  logic [31:0] sram_rdata,
  input  logic        sram_wait,
  input  key_frame_t  key_frame,
  output logic [31:0] readdata,
  output logic        waitrequest
);

  // priority select, only sram can stall
  always_comb begin
    if (region == REGION_SRAM) begin
      readdata    = sram_rdata;
      waitrequest = sram_wait;
    end else if (region == REGION_KEYB) begin
      readdata    = 32'(key_frame);  // {valid, bits}, upper zero
      waitrequest = 1'b0;
    end else begin
      readdata    = '0;              // video, cache, unmapped
      waitrequest = 1'b0;
    end
  end

endmodule

//--- rtl/sys_fabric.sv
`timescale 1ns/1ps

module sys_fabric
  import bus_pkg::*, periph_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  input  bus_req_t    bus_req,
  output logic [31:0] readdata,
  output logic        waitrequest,
  input  logic        key_clk,
  input  logic        key_data,
  output flush_ctl_t  cache_ctl,
  output vga_ctl_t    vga_ctl
);

  region_e               region;
  logic [WORD_OFS_W-1:0] word_ofs;
  logic [31:0]           sram_rdata;
  logic                  sram_wait;
  key_frame_t            key_frame;

  bus_decoder u_decoder (
    .bus_req  (bus_req),
    .region   (region),
    .word_ofs (word_ofs)
  );

  main_sram u_sram (
    .clk      (clk),
    .reset_n  (reset_n),
    .bus_req  (bus_req),
    .region   (region),
    .rdata    (sram_rdata),
    .wait_req (sram_wait)
  );

  ctrl_regs u_ctrl (
    .clk       (clk),
    .reset_n   (reset_n),
    .bus_req   (bus_req),
    .region    (region),
    .word_ofs  (word_ofs),
    .cache_ctl (cache_ctl),
    .vga_ctl   (vga_ctl)
  );

  ps2_key_rx u_keyb (
    .clk      (clk),
    .reset_n  (reset_n),
    .key_clk  (key_clk),
    .key_data (key_data),
    .bus_req  (bus_req),
    .region   (region),
    .frame    (key_frame)
  );

  read_return u_return (
    .region      (region),
    .sram_rdata  (sram_rdata),
    .sram_wait   (sram_wait),
    .key_frame   (key_frame),
    .readdata    (readdata),
    .waitrequest (waitrequest)
  );

endmodule

//--- tb/tb_sys_fabric.sv
`timescale 1ns/1ps

module tb_sys_fabric
  import bus_pkg::*, periph_pkg::*;
();

  localparam logic [2:0] OP_WR        = 3'd0; // bus write
  localparam logic [2:0] OP_RD        = 3'd1; // bus read, checked
  localparam logic [2:0] OP_CHK_CACHE = 3'd2; // compare cache_ctl port
  localparam logic [2:0] OP_CHK_VGA   = 3'd3; // compare vga_ctl port
  localparam logic [2:0] OP_KEY_FRAME = 3'd4; // send one ps2 frame
  localparam logic [2:0] OP_KEY_RESYNC = 3'd5; // 3 stray edges, idle, frame
  localparam int BUS_TIMEOUT = 8;             // cycles of waitrequest
  localparam int PS2_PHASE   = 4;             // clk cycles per ps2 phase

  typedef struct packed {
    logic [2:0]  op;
    logic [31:0] address;
    logic [31:0] wdata;    // write word, scan code for key ops
    logic [3:0]  be;
    logic [31:0] expected; // read data or port value
    logic [1:0]  exp_wait; // stall cycles on a bus access
  } access_t;

  logic        clk;
  logic        reset_n;
  logic        key_clk;
  logic        key_data;
  bus_req_t    bus_req;
  logic [31:0] readdata;
  logic        waitrequest;
  flush_ctl_t  cache_ctl;
  vga_ctl_t    vga_ctl;

  access_t     table_q[$];
  logic [31:0] sram_ref [SRAM_WORDS]; // reference copy of the sram
  logic [31:0] rng_state;

  sys_fabric u_dut (
    .clk         (clk),
    .reset_n     (reset_n),
    .bus_req     (bus_req),
    .readdata    (readdata),
    .waitrequest (waitrequest),
    .key_clk     (key_clk),
    .key_data    (key_data),
    .cache_ctl   (cache_ctl),
    .vga_ctl     (vga_ctl)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // lanes with be set take the new byte
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  be);
    logic [31:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (new_word & mask) | (old_word & ~mask);
  endfunction

  // {valid, parity, d7..d0, start} zero extended
  function automatic logic [31:0] key_word(input logic [7:0] code, input logic valid);
    return {21'd0, valid, ~^code, code, 1'b0};
  endfunction

  function automatic logic [31:0] reg_addr(input logic [15:0] tag, input logic [3:0] ofs);
    return {tag, 10'd0, ofs, 2'b00};
  endfunction

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic add_op(input logic [2:0] op, input logic [31:0] address,
                        input logic [31:0] wdata, input logic [3:0] be,
                        input logic [31:0] expected, input logic [1:0] exp_wait);
    table_q.push_back({op, address, wdata, be, expected, exp_wait});
  endtask

  task automatic add_sram_write(input logic [8:0] idx, input logic [31:0] data,
                                input logic [3:0] be);
    sram_ref[idx] = merge_bytes(sram_ref[idx], data, be); // model first
    add_op(OP_WR, {SRAM_TAG, 5'd0, idx, 2'b00}, data, be, 32'd0, 2'd0);
  endtask

  task automatic add_sram_read(input logic [8:0] idx);
    add_op(OP_RD, {SRAM_TAG, 5'd0, idx, 2'b00}, 32'd0, 4'hF, sram_ref[idx], 2'd1);
  endtask

  task automatic build_table();
    logic [8:0] idx [6];
    rng_state = 32'hb34e;
    // reset values, idle keyboard
    add_op(OP_CHK_CACHE, 32'd0, 32'd0, 4'h0, 32'd0, 2'd0);
    add_op(OP_CHK_VGA, 32'd0, 32'd0, 4'h0, {13'd0, 2'd3, 16'h0000, 1'b0}, 2'd0);
    add_op(OP_RD, reg_addr(KEYB_TAG, 4'd0), 32'd0, 4'hF, 32'd0, 2'd0);
    for (int n = 0; n < 6; n++) begin
      rng_state = lcg_next(rng_state);
      idx[n]    = rng_state[24:16];  // random word index
      rng_state = lcg_next(rng_state);
      add_sram_write(idx[n], rng_state, 4'hF);
    end
    for (int n = 0; n < 6; n++) begin
      rng_state = lcg_next(rng_state);
      add_sram_write(idx[n], rng_state, 4'(n + 1)); // partial lanes only
    end
    for (int n = 0; n < 6; n++) begin
      add_sram_read(idx[n]);
    end
    add_sram_read(idx[0]);             // same word twice, rearm check
    // video fields by offset, then cache flush
    add_op(OP_WR, reg_addr(VIDEO_TAG, 4'd0), 32'hFFFF_FFF6, 4'hF, 32'd0, 2'd0);
    add_op(OP_CHK_VGA, 32'd0, 32'd0, 4'h0, {13'd0, 2'd2, 16'h0000, 1'b0}, 2'd0);
    add_op(OP_WR, reg_addr(VIDEO_TAG, 4'd1), 32'h5A5A_C3E1, 4'hF, 32'd0, 2'd0);
    add_op(OP_CHK_VGA, 32'd0, 32'd0, 4'h0, {13'd0, 2'd2, 16'hC3E1, 1'b0}, 2'd0);
    add_op(OP_WR, reg_addr(VIDEO_TAG, 4'd2), 32'h0000_0003, 4'hF, 32'd0, 2'd0);
    add_op(OP_CHK_VGA, 32'd0, 32'd0, 4'h0, {13'd0, 2'd2, 16'hC3E1, 1'b1}, 2'd0);
    add_op(OP_WR, reg_addr(VIDEO_TAG, 4'd3), 32'hFFFF_FFFF, 4'hF, 32'd0, 2'd0);
    add_op(OP_CHK_VGA, 32'd0, 32'd0, 4'h0, {13'd0, 2'd2, 16'hC3E1, 1'b1}, 2'd0);
    add_op(OP_WR, reg_addr(CACHE_TAG, 4'd0), 32'h8000_7ABC, 4'hF, 32'd0, 2'd0);
    add_op(OP_CHK_CACHE, 32'd0, 32'd0, 4'h0, {16'd0, 1'b1, 15'h7ABC}, 2'd0);
    add_op(OP_WR, reg_addr(CACHE_TAG, 4'd1), 32'h0000_1111, 4'hF, 32'd0, 2'd0);
    add_op(OP_CHK_CACHE, 32'd0, 32'd0, 4'h0, {16'd0, 1'b1, 15'h7ABC}, 2'd0);
    add_op(OP_WR, reg_addr(CACHE_TAG, 4'd0), 32'h0001_2345, 4'hF, 32'd0, 2'd0);
    add_op(OP_CHK_CACHE, 32'd0, 32'd0, 4'h0, {16'd0, 1'b0, 15'h2345}, 2'd0);
    add_op(OP_RD, reg_addr(VIDEO_TAG, 4'd1), 32'd0, 4'hF, 32'd0, 2'd0);
    add_op(OP_RD, reg_addr(CACHE_TAG, 4'd0), 32'd0, 4'hF, 32'd0, 2'd0);
    add_op(OP_RD, 32'h0000_0040, 32'd0, 4'hF, 32'd0, 2'd0); // old sdram area
    add_op(OP_RD, 32'h0100_0000, 32'd0, 4'hF, 32'd0, 2'd0);
    // keyboard frame, read clears valid
    add_op(OP_KEY_FRAME, 32'd0, 32'h0000_001C, 4'h0, 32'd0, 2'd0);
    add_op(OP_RD, reg_addr(KEYB_TAG, 4'd0), 32'd0, 4'hF, key_word(8'h1C, 1'b1), 2'd0);
    add_op(OP_RD, reg_addr(KEYB_TAG, 4'd0), 32'd0, 4'hF, key_word(8'h1C, 1'b0), 2'd0);
    add_op(OP_KEY_RESYNC, 32'd0, 32'h0000_00A7, 4'h0, 32'd0, 2'd0);
    add_op(OP_RD, reg_addr(KEYB_TAG, 4'd0), 32'd0, 4'hF, key_word(8'hA7, 1'b1), 2'd0);
  endtask

  // one access, stalls counted at the falling edge
  task automatic bus_access(input access_t e, output logic [31:0] rdata, output int waits);
    @(posedge clk);
    #1;
    bus_req.address    = e.address;
    bus_req.read       = (e.op == OP_RD);
    bus_req.write      = (e.op == OP_WR);
    bus_req.writedata  = e.wdata;
    bus_req.byteenable = e.be;
    waits = 0;
    @(negedge clk);
    while (waitrequest && waits < BUS_TIMEOUT) begin
      waits++;
      @(negedge clk);
    end
    if (waitrequest) begin
      abort_run($sformatf("timeout at %0t: waitrequest stuck high for address %h",
                          $time, e.address));
    end
    rdata = readdata;                 // completion cycle
    @(posedge clk);
    #1;
    bus_req.read  = 1'b0;
    bus_req.write = 1'b0;
  endtask

  task automatic ps2_bit(input logic value);
    key_data = value;
    repeat (PS2_PHASE) @(posedge clk);
    #1;
    key_clk = 1'b0;                   // receiver samples on this fall
    repeat (PS2_PHASE) @(posedge clk);
    #1;
    key_clk = 1'b1;
    repeat (PS2_PHASE) @(posedge clk);
    #1;
  endtask

  task automatic ps2_send(input logic [7:0] code, input int nbits);
    logic [10:0] frame_bits;
    frame_bits = {1'b1, ~^code, code, 1'b0}; // stop, odd parity, data, start
    for (int i = 0; i < nbits; i++) begin
      ps2_bit(frame_bits[0]);
      frame_bits = frame_bits >> 1;
    end
  endtask

  initial begin
    access_t     e;
    logic [31:0] rdata;
    int          waits;
    reset_n  = 1'b0;
    key_clk  = 1'b1;                  // ps2 idles high
    key_data = 1'b1;
    bus_req  = '0;
    build_table();
    repeat (2) @(posedge clk);
    #1;
    reset_n = 1'b1;
    foreach (table_q[i]) begin
      e = table_q[i];
      case (e.op)
        OP_WR, OP_RD: begin
          bus_access(e, rdata, waits);
          assert (waits == int'(e.exp_wait))
            else abort_run($sformatf("FAILED at %0t: entry %0d saw %0d wait cycles, expected %0d",
                                     $time, i, waits, e.exp_wait));
          if (e.op == OP_RD) begin
            assert (rdata === e.expected)
              else abort_run($sformatf("FAILED at %0t: read %h returned %h, expected %h",
                                       $time, e.address, rdata, e.expected));
          end
        end
        OP_CHK_CACHE: begin
          assert ({16'd0, cache_ctl} === e.expected)
            else abort_run($sformatf("FAILED at %0t: cache_ctl %h, expected %h",
                                     $time, cache_ctl, e.expected));
        end
        OP_CHK_VGA: begin
          assert ({13'd0, vga_ctl} === e.expected)
            else abort_run($sformatf("FAILED at %0t: vga_ctl %h, expected %h",
                                     $time, vga_ctl, e.expected));
        end
        OP_KEY_FRAME: begin
          ps2_send(e.wdata[7:0], 11);
        end
        default: begin                // resync case
          ps2_send(~e.wdata[7:0], 3);  // stray partial frame
          repeat (int'(KEY_IDLE_TIMEOUT) + 100) @(posedge clk);
          #1;
          ps2_send(e.wdata[7:0], 11);
        end
      endcase
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

//--- verilog.f
rtl/bus_pkg.sv
rtl/periph_pkg.sv
rtl/bus_decoder.sv
rtl/main_sram.sv
rtl/ctrl_regs.sv
rtl/ps2_key_rx.sv
rtl/read_return.sv
rtl/sys_fabric.sv
tb/tb_sys_fabric.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run tb_sys_fabric with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_sys_fabric -Mdir "$build_dir" -o tb_sys_fabric \
  -f verilog.f
if [ $? -ne 0 ]; then
  echo "error: verilator build failed"
  exit 1
fi

"./$build_dir/tb_sys_fabric" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
  echo "error: simulation exited with status $run_status"
  exit 1
fi

if grep -qx "Simulation completed successfully" "$log_file"; then
  echo "RESULT: PASS"
  exit 0
fi
echo "RESULT: FAIL"
exit 1
